// File: bench/blimp_core_tb.sv
module blimp_core_tb;

  localparam int mem_words    = 64;
  localparam int num_rows     = 25;
  localparam int reset_cycles = 10;
  localparam int max_cycles   = num_rows * 20 + reset_cycles;  // 20 per row plus reset

  logic                               clk;
  logic                               reset;
  logic                               mem_req;
  logic                               mem_we;
  logic [blimp_pkg::xlen-1:0]          mem_addr;
  logic [blimp_pkg::xlen-1:0]          mem_wdata;
  logic [blimp_pkg::xlen-1:0]          mem_rdata;
  logic                               mem_rvalid;
  logic                               trace_val;
  logic [blimp_pkg::xlen-1:0]          trace_pc;
  logic [blimp_pkg::reg_addr_bits-1:0] trace_waddr;
  logic [blimp_pkg::xlen-1:0]          trace_wdata;
  logic                               trace_wen;
  logic [blimp_pkg::xlen-1:0]          image [mem_words];  // Memory at reset

  // ------------------------------
  // Program and expected commits
  // ------------------------------

  logic [blimp_pkg::xlen-1:0]          row_inst    [num_rows];
  logic                               row_commits [num_rows];  // Clear where a jump skips
  logic [blimp_pkg::reg_addr_bits-1:0] row_waddr   [num_rows];
  logic                               row_wen     [num_rows];
  logic [blimp_pkg::xlen-1:0]          row_wdata   [num_rows];
  int rows_loaded;
  int rows_checked;
  int rows_passed;
  int error_count;
  int cycle_count;

  blimp_core #(
    .p_seq_num_bits (3),
    .p_mul_stages   (3)
  ) blimp_core_i (
    .clk         (clk),
    .reset       (reset),
    .mem_req     (mem_req),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_rdata   (mem_rdata),
    .mem_rvalid  (mem_rvalid),
    .trace_val   (trace_val),
    .trace_pc    (trace_pc),
    .trace_waddr (trace_waddr),
    .trace_wdata (trace_wdata),
    .trace_wen   (trace_wen)
  );

  blimp_mem_model #(
    .mem_words (mem_words)
  ) mem_model_i (
    .clk        (clk),
    .reset      (reset),
    .mem_req    (mem_req),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_rdata  (mem_rdata),
    .mem_rvalid (mem_rvalid),
    .image      (image)
  );

  // Instruction word from its fields
  function automatic logic [blimp_pkg::xlen-1:0] encode(
    input blimp_pkg::op_e                      op,
    input logic [blimp_pkg::reg_addr_bits-1:0] rd,
    input logic [blimp_pkg::reg_addr_bits-1:0] rs1,
    input logic [blimp_pkg::reg_addr_bits-1:0] rs2,
    input logic [blimp_pkg::imm_bits-1:0]      imm
  );
    logic [blimp_pkg::xlen-1:0] word;
    word = '0;
    word[blimp_pkg::op_msb:blimp_pkg::op_lsb]   = op;
    word[blimp_pkg::rd_msb:blimp_pkg::rd_lsb]   = rd;
    word[blimp_pkg::rs1_msb:blimp_pkg::rs1_lsb] = rs1;
    word[blimp_pkg::rs2_msb:blimp_pkg::rs2_lsb] = rs2;
    word[blimp_pkg::imm_msb:blimp_pkg::imm_lsb] = imm;
    return word;
  endfunction

  task automatic put_row(input logic [blimp_pkg::xlen-1:0] inst, input logic commits,
                         input logic [blimp_pkg::reg_addr_bits-1:0] waddr, input logic wen,
                         input logic [blimp_pkg::xlen-1:0] wdata);
    if (rows_loaded < num_rows) begin
      row_inst[rows_loaded]    = inst;
      row_commits[rows_loaded] = commits;
      row_waddr[rows_loaded]   = waddr;
      row_wen[rows_loaded]     = wen;
      row_wdata[rows_loaded]   = wdata;
    end
    rows_loaded++;
  endtask

  task automatic load_program();
    rows_loaded = 0;
    // Dependent addi/add chain, r0 stays zero
    put_row(encode(blimp_pkg::op_addi, 3'd1, 3'd0, 3'd0, 16'd5), 1'b1, 3'd1, 1'b1, 32'd5);
    put_row(encode(blimp_pkg::op_addi, 3'd2, 3'd1, 3'd0, 16'd7), 1'b1, 3'd2, 1'b1, 32'd12);
    put_row(encode(blimp_pkg::op_add, 3'd3, 3'd1, 3'd2, 16'd0), 1'b1, 3'd3, 1'b1, 32'd17);
    put_row(encode(blimp_pkg::op_addi, 3'd0, 3'd3, 3'd0, 16'd100), 1'b1, 3'd0, 1'b0, 32'd0);
    put_row(encode(blimp_pkg::op_add, 3'd4, 3'd0, 3'd3, 16'd0), 1'b1, 3'd4, 1'b1, 32'd17);
    // Slow mul, then a fast independent addi (-2)
    put_row(encode(blimp_pkg::op_mul, 3'd5, 3'd2, 3'd3, 16'd0), 1'b1, 3'd5, 1'b1, 32'd204);
    put_row(encode(blimp_pkg::op_addi, 3'd6, 3'd1, 3'd0, 16'hfffe), 1'b1, 3'd6, 1'b1, 32'd3);
    put_row(encode(blimp_pkg::op_add, 3'd7, 3'd5, 3'd6, 16'd0), 1'b1, 3'd7, 1'b1, 32'd207);
    // Store then load back, users right behind the load
    put_row(encode(blimp_pkg::op_sw, 3'd0, 3'd0, 3'd7, 16'd240), 1'b1, 3'd0, 1'b0, 32'd0);
    put_row(encode(blimp_pkg::op_lw, 3'd1, 3'd0, 3'd0, 16'd240), 1'b1, 3'd1, 1'b1, 32'd207);
    put_row(encode(blimp_pkg::op_addi, 3'd2, 3'd1, 3'd0, 16'd1), 1'b1, 3'd2, 1'b1, 32'd208);
    put_row(encode(blimp_pkg::op_mul, 3'd3, 3'd1, 3'd1, 16'd0), 1'b1, 3'd3, 1'b1, 32'd42849);
    put_row(encode(blimp_pkg::op_addi, 3'd4, 3'd0, 3'd0, 16'hffff), 1'b1, 3'd4, 1'b1, '1);
    // Low word of -1 * 42849
    put_row(encode(blimp_pkg::op_mul, 3'd5, 3'd4, 3'd3, 16'd0), 1'b1, 3'd5, 1'b1,
            32'hffff_589f);
    // jal over two words, link is pc + 4
    put_row(encode(blimp_pkg::op_jal, 3'd5, 3'd0, 3'd0, 16'd12), 1'b1, 3'd5, 1'b1, 32'd60);
    put_row(encode(blimp_pkg::op_addi, 3'd6, 3'd0, 3'd0, 16'd111), 1'b0, 3'd0, 1'b0, 32'd0);
    put_row(encode(blimp_pkg::op_addi, 3'd6, 3'd0, 3'd0, 16'd222), 1'b0, 3'd0, 1'b0, 32'd0);
    // jalr to pc 84 through r6
    put_row(encode(blimp_pkg::op_addi, 3'd6, 3'd0, 3'd0, 16'd84), 1'b1, 3'd6, 1'b1, 32'd84);
    put_row(encode(blimp_pkg::op_jalr, 3'd7, 3'd6, 3'd0, 16'd0), 1'b1, 3'd7, 1'b1, 32'd76);
    put_row(encode(blimp_pkg::op_addi, 3'd1, 3'd0, 3'd0, 16'd333), 1'b0, 3'd0, 1'b0, 32'd0);
    put_row(encode(blimp_pkg::op_mul, 3'd1, 3'd1, 3'd1, 16'd0), 1'b0, 3'd0, 1'b0, 32'd0);
    put_row(encode(blimp_pkg::op_add, 3'd1, 3'd5, 3'd7, 16'd0), 1'b1, 3'd1, 1'b1, 32'd136);
    put_row(encode(blimp_pkg::op_sw, 3'd0, 3'd0, 3'd1, 16'd244), 1'b1, 3'd0, 1'b0, 32'd0);
    put_row(encode(blimp_pkg::op_lw, 3'd2, 3'd0, 3'd0, 16'd244), 1'b1, 3'd2, 1'b1, 32'd136);
    // Park on a jump to itself
    put_row(encode(blimp_pkg::op_jal, 3'd0, 3'd0, 3'd0, 16'd0), 1'b1, 3'd0, 1'b0, 32'd0);
  endtask

  task automatic fill_image();
    for (int i = 0; i < mem_words; i++) begin
      if (i < num_rows) image[i] = row_inst[i];
      else              image[i] = $urandom();  // Unused words get noise
    end
  endtask

  // Commit strobe is stable by the falling edge
  task automatic wait_commit();
    @(negedge clk);
    while (!trace_val) @(negedge clk);
  endtask

  task automatic check_commit(input int r);
    logic [blimp_pkg::xlen-1:0] exp_pc;
    int errs;
    exp_pc = r * 4;
    errs   = 0;
    if (trace_pc != exp_pc) begin
      $display("Fail at %0t: row %0d pc is %0d, expected %0d", $time, r, trace_pc, exp_pc);
      errs++;
    end
    if (trace_waddr != row_waddr[r]) begin
      $display("Fail at %0t: row %0d waddr is %0d, expected %0d",
               $time, r, trace_waddr, row_waddr[r]);
      errs++;
    end
    if (trace_wen != row_wen[r]) begin
      $display("Fail at %0t: row %0d wen is %0b, expected %0b", $time, r, trace_wen, row_wen[r]);
      errs++;
    end
    if (row_wen[r] && trace_wdata != row_wdata[r]) begin  // Data only matters when written
      $display("Fail at %0t: row %0d wdata is %h, expected %h",
               $time, r, trace_wdata, row_wdata[r]);
      errs++;
    end
    rows_checked++;
    error_count += errs;
    if (errs == 0) begin
      rows_passed++;
      $display("Row %0d at pc %0d ok", r, exp_pc);
    end else begin
      $display("Row %0d at pc %0d has %0d mismatches", r, exp_pc, errs);
    end
  endtask

  // ------------------------------
  // Clock, timeout, main sequence
  // ------------------------------

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, only %0d commits seen, the core hangs",
             cycle_count, rows_checked);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    reset        = 1'b1;
    rows_checked = 0;
    rows_passed  = 0;
    error_count  = 0;
    void'($urandom(99808));  // Seed once
    load_program();
    if (rows_loaded != num_rows) begin
      $display("Program table holds %0d rows instead of %0d", rows_loaded, num_rows);
      error_count++;
    end
    fill_image();
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    for (int r = 0; r < num_rows; r++) begin
      if (row_commits[r]) begin
        wait_commit();
        check_commit(r);
      end
    end
    $display("Rows checked %0d, passed %0d, errors %0d", rows_checked, rows_passed, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: bench/blimp_mem_model.sv
module blimp_mem_model #(
  parameter int mem_words = 64
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       mem_req,
  input  logic                       mem_we,
  input  logic [blimp_pkg::xlen-1:0] mem_addr,
  input  logic [blimp_pkg::xlen-1:0] mem_wdata,
  output logic [blimp_pkg::xlen-1:0] mem_rdata,
  output logic                       mem_rvalid,
  input  logic [blimp_pkg::xlen-1:0] image [mem_words]  // Contents loaded during reset
);

  localparam int idx_bits = $clog2(mem_words);

  logic [blimp_pkg::xlen-1:0] mem [mem_words];
  logic [idx_bits-1:0]        idx;

  assign idx = mem_addr[idx_bits+1:2];  // Word index, wraps past the top

  // One request in, one response pulse on the next cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      mem        <= image;
      mem_rvalid <= 1'b0;
      mem_rdata  <= '0;
    end else begin
      mem_rvalid <= mem_req;  // Stores get their pulse too
      if (mem_req && mem_we) mem[idx] <= mem_wdata;
      if (mem_req) mem_rdata <= mem[idx];
    end
  end

endmodule

// File: blimp_core.f
hw/blimp_pkg.sv
hw/fetch_unit.sv
hw/decode_issue_unit.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/load_store_unit.sv
hw/mem_arbiter.sv
hw/writeback_commit_unit.sv
hw/blimp_core.sv
bench/blimp_mem_model.sv
bench/blimp_core_tb.sv

// File: hw/alu_unit.sv
module alu_unit #(
  parameter int p_seq_num_bits = 3
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               alu_issue,
  input  blimp_pkg::op_e                     x_op,
  input  logic [p_seq_num_bits-1:0]          x_seq,
  input  logic [blimp_pkg::reg_addr_bits-1:0] x_waddr,
  input  logic                               x_wen,
  input  logic [blimp_pkg::xlen-1:0]          x_op_a,
  input  logic [blimp_pkg::xlen-1:0]          x_op_b,
  input  logic [blimp_pkg::xlen-1:0]          x_imm,
  output logic                               alu_cpl,
  output logic [p_seq_num_bits-1:0]          alu_seq,
  output logic [blimp_pkg::reg_addr_bits-1:0] alu_waddr,
  output logic                               alu_wen,
  output logic [blimp_pkg::xlen-1:0]          alu_wdata
);

  always_ff @(posedge clk) begin
    if (reset) alu_cpl <= 1'b0;
    else       alu_cpl <= alu_issue;  // One cycle latency
  end

  always_ff @(posedge clk) begin
    if (alu_issue) begin
      alu_seq   <= x_seq;
      alu_waddr <= x_waddr;
      alu_wen   <= x_wen;
      // Register operand for add, immediate otherwise
      alu_wdata <= x_op_a + ((x_op == blimp_pkg::op_add) ? x_op_b : x_imm);
    end
  end

endmodule

// File: hw/blimp_core.sv
module blimp_core #(
  parameter int p_seq_num_bits = 3,
  parameter int p_mul_stages   = 3
) (
  input  logic                               clk,
  input  logic                               reset,
  output logic                               mem_req,
  output logic                               mem_we,
  output logic [blimp_pkg::xlen-1:0]          mem_addr,
  output logic [blimp_pkg::xlen-1:0]          mem_wdata,
  input  logic [blimp_pkg::xlen-1:0]          mem_rdata,
  input  logic                               mem_rvalid,
  output logic                               trace_val,
  output logic [blimp_pkg::xlen-1:0]          trace_pc,
  output logic [blimp_pkg::reg_addr_bits-1:0] trace_waddr,
  output logic [blimp_pkg::xlen-1:0]          trace_wdata,
  output logic                               trace_wen
);

  // ------------------------------
  // Wires between units
  // ------------------------------

  logic if_req, if_rvalid, dm_req, dm_we, dm_rvalid;
  logic [blimp_pkg::xlen-1:0] if_addr, if_rdata, dm_addr, dm_wdata, dm_rdata;
  logic f_val, d_stall, redirect;
  logic [blimp_pkg::xlen-1:0] f_inst, f_pc, redirect_pc, d_pc;
  logic alu_issue, mul_issue, mem_issue, x_wen, mem_busy, rob_full;
  blimp_pkg::op_e x_op;
  logic [p_seq_num_bits-1:0] x_seq, alu_seq, mul_seq, mem_seq;
  logic [blimp_pkg::reg_addr_bits-1:0] x_waddr, alu_waddr, mul_waddr, mem_waddr, commit_waddr;
  logic [blimp_pkg::xlen-1:0] x_op_a, x_op_b, x_imm;
  logic alu_cpl, alu_wen, mul_cpl, mul_wen, mem_cpl, mem_wen;
  logic [blimp_pkg::xlen-1:0] alu_wdata, mul_wdata, lsu_wdata, commit_wdata;
  logic commit_val, commit_wen;

  // Trace is the commit stream
  assign trace_val   = commit_val;
  assign trace_waddr = commit_waddr;
  assign trace_wdata = commit_wdata;
  assign trace_wen   = commit_wen;

  fetch_unit fetch_unit_i (.*);

  decode_issue_unit #(
    .p_seq_num_bits (p_seq_num_bits)
  ) decode_issue_unit_i (.*);

  alu_unit #(
    .p_seq_num_bits (p_seq_num_bits)
  ) alu_unit_i (.*);

  mul_unit #(
    .p_seq_num_bits (p_seq_num_bits),
    .p_mul_stages   (p_mul_stages)
  ) mul_unit_i (.*);

  // Load result travels apart from the bus write data
  load_store_unit #(
    .p_seq_num_bits (p_seq_num_bits)
  ) load_store_unit_i (
    .*,
    .mem_wdata (lsu_wdata)
  );

  mem_arbiter mem_arbiter_i (.*);  // Fetch and data share one port

  writeback_commit_unit #(
    .p_seq_num_bits (p_seq_num_bits)
  ) writeback_commit_unit_i (
    .*,
    .mem_wdata (lsu_wdata)  // Memory pipe completion data
  );

endmodule

// File: hw/blimp_pkg.sv
package blimp_pkg;

  // ------------------------------
  // Widths
  // ------------------------------

  localparam int xlen          = 32;  // Data and address width
  localparam int num_arch_regs = 8;
  localparam int reg_addr_bits = 3;

  // Opcode in the top three bits of every word
  typedef enum logic [2:0] {
    op_add  = 3'd0,  // rd = rs1 + rs2
    op_addi = 3'd1,  // rd = rs1 + imm
    op_mul  = 3'd2,  // rd = low word of rs1 * rs2
    op_lw   = 3'd3,  // rd = mem[rs1 + imm]
    op_sw   = 3'd4,  // mem[rs1 + imm] = rs2
    op_jal  = 3'd5,  // rd = pc + 4, pc = pc + imm
    op_jalr = 3'd6,  // rd = pc + 4, pc = rs1 + imm
    op_nop  = 3'd7
  } op_e;

  typedef enum logic [1:0] {
    pipe_alu = 2'd0,
    pipe_mul = 2'd1,
    pipe_mem = 2'd2
  } pipe_e;

  // ------------------------------
  // Instruction fields
  // ------------------------------

  localparam int op_msb  = 31;
  localparam int op_lsb  = 29;
  localparam int rd_msb  = 28;
  localparam int rd_lsb  = 26;
  localparam int rs1_msb = 25;
  localparam int rs1_lsb = 23;
  localparam int rs2_msb = 22;
  localparam int rs2_lsb = 20;
  localparam int imm_msb = 15;  // Signed byte offset
  localparam int imm_lsb = 0;
  localparam int imm_bits = imm_msb - imm_lsb + 1;

endpackage

// File: hw/decode_issue_unit.sv
module decode_issue_unit #(
  parameter int p_seq_num_bits = 3
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               f_val,
  input  logic [blimp_pkg::xlen-1:0]          f_inst,
  input  logic [blimp_pkg::xlen-1:0]          f_pc,
  output logic                               d_stall,
  output logic                               redirect,
  output logic [blimp_pkg::xlen-1:0]          redirect_pc,
  output logic                               alu_issue,
  output logic                               mul_issue,
  output logic                               mem_issue,
  output blimp_pkg::op_e                     x_op,
  output logic [p_seq_num_bits-1:0]          x_seq,
  output logic [blimp_pkg::reg_addr_bits-1:0] x_waddr,
  output logic                               x_wen,
  output logic [blimp_pkg::xlen-1:0]          x_op_a,
  output logic [blimp_pkg::xlen-1:0]          x_op_b,
  output logic [blimp_pkg::xlen-1:0]          x_imm,
  input  logic                               mem_busy,
  input  logic                               rob_full,
  input  logic                               commit_val,
  input  logic [blimp_pkg::reg_addr_bits-1:0] commit_waddr,
  input  logic                               commit_wen,
  input  logic [blimp_pkg::xlen-1:0]          commit_wdata,
  output logic [blimp_pkg::xlen-1:0]          d_pc
);

  localparam logic [blimp_pkg::xlen-1:0] link_off = 4;

  blimp_pkg::op_e   op;
  blimp_pkg::pipe_e pipe;
  logic [blimp_pkg::reg_addr_bits-1:0] rd, rs1, rs2;
  logic [blimp_pkg::xlen-1:0] imm, rs1_val, rs2_val;
  logic uses_rs1, uses_rs2, writes_rd, is_jump, hazard, issue;
  logic [blimp_pkg::xlen-1:0] regs [blimp_pkg::num_arch_regs];  // Architectural registers
  logic [blimp_pkg::num_arch_regs-1:0] pending;                 // Scoreboard

  // ------------------------------
  // Field decode
  // ------------------------------

  assign op  = blimp_pkg::op_e'(f_inst[blimp_pkg::op_msb:blimp_pkg::op_lsb]);
  assign rd  = f_inst[blimp_pkg::rd_msb:blimp_pkg::rd_lsb];
  assign rs1 = f_inst[blimp_pkg::rs1_msb:blimp_pkg::rs1_lsb];
  assign rs2 = f_inst[blimp_pkg::rs2_msb:blimp_pkg::rs2_lsb];
  assign imm = {{(blimp_pkg::xlen - blimp_pkg::imm_bits){f_inst[blimp_pkg::imm_msb]}},
                f_inst[blimp_pkg::imm_msb:blimp_pkg::imm_lsb]};

  always_comb begin
    pipe      = blimp_pkg::pipe_alu;  // Jumps and nop ride the ALU too
    uses_rs1  = 1'b1;
    uses_rs2  = 1'b0;
    writes_rd = 1'b1;
    case (op)
      blimp_pkg::op_add: uses_rs2 = 1'b1;
      blimp_pkg::op_mul: begin
        pipe     = blimp_pkg::pipe_mul;
        uses_rs2 = 1'b1;
      end
      blimp_pkg::op_lw:  pipe = blimp_pkg::pipe_mem;
      blimp_pkg::op_sw: begin
        pipe      = blimp_pkg::pipe_mem;
        uses_rs2  = 1'b1;
        writes_rd = 1'b0;
      end
      blimp_pkg::op_jal: uses_rs1 = 1'b0;
      blimp_pkg::op_nop: begin
        uses_rs1  = 1'b0;
        writes_rd = 1'b0;
      end
      default: ;
    endcase
  end

  // ------------------------------
  // Operands and hazards
  // ------------------------------

  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];  // r0 reads as zero
  assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];
  assign x_wen   = writes_rd && (rd != '0);      // Writes to r0 are dropped here

  assign hazard  = (uses_rs1 && pending[rs1]) || (uses_rs2 && pending[rs2])
                || (x_wen && pending[rd]);       // RAW or WAW
  assign d_stall = f_val && (hazard || rob_full || (pipe == blimp_pkg::pipe_mem && mem_busy));
  assign issue   = f_val && !d_stall;

  assign is_jump = (op == blimp_pkg::op_jal) || (op == blimp_pkg::op_jalr);
  assign x_op    = is_jump ? blimp_pkg::op_addi : op;  // Link as pc + 4
  assign x_op_a  = is_jump ? f_pc : rs1_val;
  assign x_op_b  = rs2_val;
  assign x_imm   = is_jump ? link_off : imm;
  assign x_waddr = rd;
  assign d_pc    = f_pc;

  assign redirect    = issue && is_jump;
  assign redirect_pc = ((op == blimp_pkg::op_jal) ? f_pc : rs1_val) + imm;

  assign alu_issue = issue && (pipe == blimp_pkg::pipe_alu);
  assign mul_issue = issue && (pipe == blimp_pkg::pipe_mul);
  assign mem_issue = issue && (pipe == blimp_pkg::pipe_mem);

  always_ff @(posedge clk) begin
    if (commit_val && commit_wen) regs[commit_waddr] <= commit_wdata;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= '0;
      x_seq   <= '0;
    end else begin
      if (commit_val && commit_wen) pending[commit_waddr] <= 1'b0;
      if (issue && x_wen) pending[rd] <= 1'b1;
      if (issue) x_seq <= x_seq + 1'b1;  // Wraps with the ROB
    end
  end

endmodule

// File: hw/fetch_unit.sv
module fetch_unit (
  input  logic                      clk,
  input  logic                      reset,
  output logic                      if_req,
  output logic [blimp_pkg::xlen-1:0] if_addr,
  input  logic [blimp_pkg::xlen-1:0] if_rdata,
  input  logic                      if_rvalid,
  output logic                      f_val,
  output logic [blimp_pkg::xlen-1:0] f_inst,
  output logic [blimp_pkg::xlen-1:0] f_pc,
  input  logic                      d_stall,
  input  logic                      redirect,
  input  logic [blimp_pkg::xlen-1:0] redirect_pc
);

  logic [blimp_pkg::xlen-1:0] pc;  // Next word to request
  logic in_flight;                 // Request held until its rvalid
  logic stale;                     // Response belongs to the old path
  logic consume;
  logic take;

  assign consume = f_val && !d_stall;  // Redirect always comes with this
  assign take    = if_rvalid && !stale && !redirect;

  // Start a new fetch once the buffer is free or emptying
  assign if_req  = in_flight || !f_val || consume;
  assign if_addr = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc        <= '0;
      f_val     <= 1'b0;
      in_flight <= 1'b0;
      stale     <= 1'b0;
    end else begin
      in_flight <= if_req && !if_rvalid;
      if (if_rvalid) stale <= 1'b0;
      else if (redirect && if_req) stale <= 1'b1;  // Drop the answer still coming
      if (consume) f_val <= 1'b0;
      if (take) begin
        f_val <= 1'b1;
        pc    <= pc + 4;
      end
      if (redirect) pc <= redirect_pc;  // Restart on the jump target
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      f_inst <= if_rdata;
      f_pc   <= pc;
    end
  end

endmodule

// File: hw/load_store_unit.sv
module load_store_unit #(
  parameter int p_seq_num_bits = 3
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               mem_issue,
  input  blimp_pkg::op_e                     x_op,
  input  logic [p_seq_num_bits-1:0]          x_seq,
  input  logic [blimp_pkg::reg_addr_bits-1:0] x_waddr,
  input  logic                               x_wen,
  input  logic [blimp_pkg::xlen-1:0]          x_op_a,
  input  logic [blimp_pkg::xlen-1:0]          x_op_b,
  input  logic [blimp_pkg::xlen-1:0]          x_imm,
  output logic                               mem_busy,
  output logic                               dm_req,
  output logic                               dm_we,
  output logic [blimp_pkg::xlen-1:0]          dm_addr,
  output logic [blimp_pkg::xlen-1:0]          dm_wdata,
  input  logic [blimp_pkg::xlen-1:0]          dm_rdata,
  input  logic                               dm_rvalid,
  output logic                               mem_cpl,
  output logic [p_seq_num_bits-1:0]          mem_seq,
  output logic [blimp_pkg::reg_addr_bits-1:0] mem_waddr,
  output logic                               mem_wen,
  output logic [blimp_pkg::xlen-1:0]          mem_wdata
);

  assign dm_req = mem_busy;  // Level until the response

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_busy <= 1'b0;
      mem_cpl  <= 1'b0;
    end else begin
      mem_cpl <= mem_busy && dm_rvalid;
      if (mem_issue) mem_busy <= 1'b1;
      else if (dm_rvalid) mem_busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_issue) begin
      dm_we     <= (x_op == blimp_pkg::op_sw);
      dm_addr   <= x_op_a + x_imm;
      dm_wdata  <= x_op_b;
      mem_seq   <= x_seq;
      mem_waddr <= x_waddr;
      mem_wen   <= x_wen;  // Clear for a store
    end
    if (dm_rvalid) mem_wdata <= dm_we ? dm_wdata : dm_rdata;  // Store shows its word
  end

endmodule

// File: hw/mem_arbiter.sv
module mem_arbiter (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      if_req,
  input  logic [blimp_pkg::xlen-1:0] if_addr,
  output logic [blimp_pkg::xlen-1:0] if_rdata,
  output logic                      if_rvalid,
  input  logic                      dm_req,
  input  logic                      dm_we,
  input  logic [blimp_pkg::xlen-1:0] dm_addr,
  input  logic [blimp_pkg::xlen-1:0] dm_wdata,
  output logic [blimp_pkg::xlen-1:0] dm_rdata,
  output logic                      dm_rvalid,
  output logic                      mem_req,
  output logic                      mem_we,
  output logic [blimp_pkg::xlen-1:0] mem_addr,
  output logic [blimp_pkg::xlen-1:0] mem_wdata,
  input  logic [blimp_pkg::xlen-1:0] mem_rdata,
  input  logic                      mem_rvalid
);

  typedef enum logic {st_idle, st_busy} state_e;

  state_e state;
  logic   owner_dm;  // Who gets the next response

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      mem_req  <= 1'b0;
      owner_dm <= 1'b0;
    end else begin
      mem_req <= 1'b0;  // Single cycle pulse
      case (state)
        st_idle: if (dm_req || if_req) begin
          state    <= st_busy;
          mem_req  <= 1'b1;
          owner_dm <= dm_req;  // Data side first
        end
        st_busy: if (mem_rvalid) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle) begin
      mem_we    <= dm_req && dm_we;
      mem_addr  <= dm_req ? dm_addr : if_addr;
      mem_wdata <= dm_wdata;
    end
  end

  // Response routing
  assign dm_rdata  = mem_rdata;
  assign if_rdata  = mem_rdata;
  assign dm_rvalid = (state == st_busy) && mem_rvalid && owner_dm;
  assign if_rvalid = (state == st_busy) && mem_rvalid && !owner_dm;

endmodule

// File: hw/mul_unit.sv
module mul_unit #(
  parameter int p_seq_num_bits = 3,
  parameter int p_mul_stages   = 3  // Two or more
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               mul_issue,
  input  logic [p_seq_num_bits-1:0]          x_seq,
  input  logic [blimp_pkg::reg_addr_bits-1:0] x_waddr,
  input  logic                               x_wen,
  input  logic [blimp_pkg::xlen-1:0]          x_op_a,
  input  logic [blimp_pkg::xlen-1:0]          x_op_b,
  output logic                               mul_cpl,
  output logic [p_seq_num_bits-1:0]          mul_seq,
  output logic [blimp_pkg::reg_addr_bits-1:0] mul_waddr,
  output logic                               mul_wen,
  output logic [blimp_pkg::xlen-1:0]          mul_wdata
);

  logic [p_mul_stages-1:0]             val_q;
  logic [p_mul_stages-1:0]             wen_q;
  logic [p_seq_num_bits-1:0]           seq_q   [p_mul_stages];
  logic [blimp_pkg::reg_addr_bits-1:0] waddr_q [p_mul_stages];
  logic [blimp_pkg::xlen-1:0]          prod_q  [p_mul_stages];

  always_ff @(posedge clk) begin
    if (reset) val_q <= '0;
    else       val_q <= {val_q[p_mul_stages-2:0], mul_issue};
  end

  // Product formed in stage 0, later stages only carry it
  always_ff @(posedge clk) begin
    seq_q[0]   <= x_seq;
    waddr_q[0] <= x_waddr;
    wen_q[0]   <= x_wen;
    prod_q[0]  <= x_op_a * x_op_b;  // Low word kept
    for (int i = 1; i < p_mul_stages; i++) begin
      seq_q[i]   <= seq_q[i-1];
      waddr_q[i] <= waddr_q[i-1];
      wen_q[i]   <= wen_q[i-1];
      prod_q[i]  <= prod_q[i-1];
    end
  end

  assign mul_cpl   = val_q[p_mul_stages-1];
  assign mul_seq   = seq_q[p_mul_stages-1];
  assign mul_waddr = waddr_q[p_mul_stages-1];
  assign mul_wen   = wen_q[p_mul_stages-1];
  assign mul_wdata = prod_q[p_mul_stages-1];

endmodule

// File: hw/writeback_commit_unit.sv
module writeback_commit_unit #(
  parameter int p_seq_num_bits = 3
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               alu_cpl,
  input  logic [p_seq_num_bits-1:0]          alu_seq,
  input  logic [blimp_pkg::reg_addr_bits-1:0] alu_waddr,
  input  logic                               alu_wen,
  input  logic [blimp_pkg::xlen-1:0]          alu_wdata,
  input  logic                               mul_cpl,
  input  logic [p_seq_num_bits-1:0]          mul_seq,
  input  logic [blimp_pkg::reg_addr_bits-1:0] mul_waddr,
  input  logic                               mul_wen,
  input  logic [blimp_pkg::xlen-1:0]          mul_wdata,
  input  logic                               mem_cpl,
  input  logic [p_seq_num_bits-1:0]          mem_seq,
  input  logic [blimp_pkg::reg_addr_bits-1:0] mem_waddr,
  input  logic                               mem_wen,
  input  logic [blimp_pkg::xlen-1:0]          mem_wdata,
  input  logic                               alu_issue,
  input  logic                               mul_issue,
  input  logic                               mem_issue,
  input  logic [p_seq_num_bits-1:0]          x_seq,
  input  logic [blimp_pkg::xlen-1:0]          d_pc,
  output logic                               rob_full,
  output logic                               commit_val,
  output logic [blimp_pkg::reg_addr_bits-1:0] commit_waddr,
  output logic                               commit_wen,
  output logic [blimp_pkg::xlen-1:0]          commit_wdata,
  output logic [blimp_pkg::xlen-1:0]          trace_pc
);

  localparam int rob_entries = 2 ** p_seq_num_bits;

  logic [p_seq_num_bits:0]             head, tail;  // Extra wrap bit
  logic [p_seq_num_bits-1:0]           head_idx;
  logic                                alloc;
  logic [rob_entries-1:0]              done;
  logic [rob_entries-1:0]              wen_q;
  logic [blimp_pkg::reg_addr_bits-1:0] waddr_q [rob_entries];
  logic [blimp_pkg::xlen-1:0]          wdata_q [rob_entries];
  logic [blimp_pkg::xlen-1:0]          pc_q    [rob_entries];

  assign alloc    = alu_issue || mul_issue || mem_issue;
  assign head_idx = head[p_seq_num_bits-1:0];
  assign rob_full = (head[p_seq_num_bits] != tail[p_seq_num_bits])
                 && (head_idx == tail[p_seq_num_bits-1:0]);

  // Oldest entry retires once done
  assign commit_val   = (head != tail) && done[head_idx];
  assign commit_waddr = waddr_q[head_idx];
  assign commit_wen   = wen_q[head_idx];
  assign commit_wdata = wdata_q[head_idx];
  assign trace_pc     = pc_q[head_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (alloc) tail <= tail + 1'b1;
      if (commit_val) head <= head + 1'b1;
    end
  end

  // ------------------------------
  // Entry writes, three pipes
  // ------------------------------

  always_ff @(posedge clk) begin
    if (alloc) begin
      done[x_seq] <= 1'b0;
      pc_q[x_seq] <= d_pc;
    end
    if (alu_cpl) begin
      done[alu_seq]    <= 1'b1;
      waddr_q[alu_seq] <= alu_waddr;
      wen_q[alu_seq]   <= alu_wen;
      wdata_q[alu_seq] <= alu_wdata;
    end
    if (mul_cpl) begin
      done[mul_seq]    <= 1'b1;
      waddr_q[mul_seq] <= mul_waddr;
      wen_q[mul_seq]   <= mul_wen;
      wdata_q[mul_seq] <= mul_wdata;
    end
    if (mem_cpl) begin
      done[mem_seq]    <= 1'b1;
      waddr_q[mem_seq] <= mem_waddr;
      wen_q[mem_seq]   <= mem_wen;
      wdata_q[mem_seq] <= mem_wdata;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# Build the core with its testbench, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --top-module blimp_core_tb -f blimp_core.f -o blimp_sim \
  && ./obj_dir/blimp_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && exit 1 || exit 0
